/* led_matrix_top.f */
rtl/led_geom_pkg.sv
rtl/led_scan_pkg.sv
rtl/frame_buffer.sv
rtl/shift_clock_gen.sv
rtl/scan_controller.sv
rtl/led_matrix_top.sv
sim/led_matrix_tb.sv

/* rtl/frame_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module frame_buffer (
  input  logic                   clk,
  input  logic                   wr_en,
  input  led_geom_pkg::fb_addr_t wr_addr,
  input  led_geom_pkg::pixel_t   wr_data,
  input  led_geom_pkg::fb_addr_t rd_addr,
  output led_geom_pkg::pixel_t   rd_data
);
  import led_geom_pkg::*;

  localparam int DEPTH = 2 ** $bits(fb_addr_t);

  pixel_t mem [DEPTH];

  // Host side
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Scan side, registered so it maps onto block RAM.
  // A read of the address being written sees the old word.
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* rtl/led_geom_pkg.sv */
`default_nettype none

package led_geom_pkg;

  localparam int PANEL_COLS = 32;
  localparam int PANEL_ROWS = 16;
  localparam int SCAN_ROWS  = 8;   // 1/8 scan, two rows per line

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } pixel_t;

  typedef logic [$clog2(PANEL_ROWS)-1:0] row_t;
  typedef logic [$clog2(PANEL_COLS)-1:0] col_t;
  typedef logic [$clog2(SCAN_ROWS)-1:0]  scan_row_t;

  // Row in the upper bits, column in the lower
  typedef logic [$clog2(PANEL_ROWS*PANEL_COLS)-1:0] fb_addr_t;

endpackage

`default_nettype wire

/* rtl/led_matrix_top.sv */
`timescale 1ns/1ns
`default_nettype none

module led_matrix_top #(
  parameter int CLK_DIV  = 6,
  parameter int PWM_BITS = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  led_geom_pkg::pixel_t pixel,
  input  led_geom_pkg::row_t   row,
  input  led_geom_pkg::col_t   col,
  input  logic                 write,
  output logic                 rgb_a,
  output logic                 rgb_b,
  output logic                 rgb_c,
  output logic [2:0]           rgb0,
  output logic [2:0]           rgb1,
  output logic                 rgb_stb,
  output logic                 rgb_clk
);
  import led_geom_pkg::*;
  import led_scan_pkg::*;

  fb_addr_t     wr_addr;
  fb_addr_t     rd_addr;
  pixel_t       rd_data;
  logic         col_tick;
  col_t         scan_col;
  hub75_drive_t drive;

  assign wr_addr = {row, col};

  frame_buffer u_frame_buffer (
    .clk     (clk),
    .wr_en   (write),
    .wr_addr (wr_addr),
    .wr_data (pixel),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  shift_clock_gen #(.CLK_DIV(CLK_DIV)) u_shift_clock_gen (
    .clk      (clk),
    .rst_n    (rst_n),
    .rgb_clk  (rgb_clk),
    .col_tick (col_tick),
    .col      (scan_col)
  );

  scan_controller #(.PWM_BITS(PWM_BITS)) u_scan_controller (
    .clk      (clk),
    .rst_n    (rst_n),
    .col_tick (col_tick),
    .col      (scan_col),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .drive    (drive)
  );

  // Panel pins
  assign rgb_a   = drive.addr[0];
  assign rgb_b   = drive.addr[1];
  assign rgb_c   = drive.addr[2];
  assign rgb0    = drive.rgb0;
  assign rgb1    = drive.rgb1;
  assign rgb_stb = drive.stb;

endmodule

`default_nettype wire

/* rtl/led_scan_pkg.sv */
`default_nettype none

package led_scan_pkg;

  typedef enum logic [2:0] {
    IDLE,
    LATCH,
    READ_TOP,
    READ_BOT,
    CAPTURE
  } scan_state_e;

  typedef struct packed {
    logic r;
    logic g;
    logic b;
  } rgb_bits_t;

  // Everything the panel connector needs, except the shift clock
  typedef struct packed {
    led_geom_pkg::scan_row_t addr;
    rgb_bits_t               rgb0;  // upper half
    rgb_bits_t               rgb1;  // lower half
    logic                    stb;
  } hub75_drive_t;

endpackage

`default_nettype wire

/* rtl/scan_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module scan_controller #(
  parameter int PWM_BITS = 8
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       col_tick,
  input  led_geom_pkg::col_t         col,
  output led_geom_pkg::fb_addr_t     rd_addr,
  input  led_geom_pkg::pixel_t       rd_data,
  output led_scan_pkg::hub75_drive_t drive
);
  import led_geom_pkg::*;
  import led_scan_pkg::*;

  localparam int ROW_W   = $bits(scan_row_t);
  localparam int PHASE_W = ROW_W + PWM_BITS;

  scan_state_e         state;
  scan_state_e         state_nxt;
  logic [PHASE_W-1:0]  phase;       // PWM level above the scan row
  logic [PWM_BITS-1:0] level;
  scan_row_t           scan_row;
  col_t                col_q;
  logic                line_pending;
  rgb_bits_t           top_bits;
  rgb_bits_t           pix_bits;

  if (PWM_BITS < 1 || PWM_BITS > 8) begin : g_pwm_check
    $error("scan_controller: PWM_BITS must be 1 to 8");
  end

  function automatic rgb_bits_t to_bits(pixel_t p, logic [PWM_BITS-1:0] lvl);
    rgb_bits_t bits;
    bits.r = (lvl < p.red[7 -: PWM_BITS]);
    bits.g = (lvl < p.green[7 -: PWM_BITS]);
    bits.b = (lvl < p.blue[7 -: PWM_BITS]);
    return bits;
  endfunction

  assign scan_row = phase[ROW_W-1:0];
  assign level    = phase[PHASE_W-1 -: PWM_BITS];
  assign pix_bits = to_bits(rd_data, level);

  // Upper row while in READ_TOP, lower partner in READ_BOT
  assign rd_addr = {state == READ_BOT, scan_row, col_q};

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (col_tick) begin
          state_nxt = (col == '0 && line_pending) ? LATCH : READ_TOP;
        end
      end
      LATCH:    state_nxt = READ_TOP;
      READ_TOP: state_nxt = READ_BOT;
      READ_BOT: state_nxt = CAPTURE;
      CAPTURE:  state_nxt = IDLE;
      default:  state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= IDLE;
      phase        <= '0;
      col_q        <= '0;
      line_pending <= 1'b0;
      drive        <= '0;
    end else begin
      state     <= state_nxt;
      drive.stb <= 1'b0;
      case (state)
        IDLE: begin
          if (col_tick) begin
            col_q <= col;
            if (state_nxt == LATCH) begin
              drive.stb    <= 1'b1;
              drive.addr   <= scan_row;  // row just shifted in
              line_pending <= 1'b0;
            end
          end
        end
        LATCH: phase <= phase + 1'b1;  // next line, level steps every 8
        CAPTURE: begin
          drive.rgb0 <= top_bits;
          drive.rgb1 <= pix_bits;
          if (col_q == col_t'(PANEL_COLS - 1)) begin
            line_pending <= 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // Upper pixel arrives one cycle after its address
  always_ff @(posedge clk) begin
    if (state == READ_BOT) begin
      top_bits <= pix_bits;
    end
  end

  a_tick_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
    col_tick |-> state == IDLE)
    else $error("col_tick outside IDLE, shift clock too fast");

  a_stb_single: assert property (@(posedge clk) disable iff (!rst_n)
    drive.stb |=> !drive.stb)
    else $error("stb high on consecutive cycles");

  a_addr_on_stb: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(drive.addr) |-> drive.stb)
    else $error("scan address moved without a latch");

endmodule

`default_nettype wire

/* rtl/shift_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module shift_clock_gen #(
  parameter int CLK_DIV = 6
) (
  input  logic               clk,
  input  logic               rst_n,
  output logic               rgb_clk,
  output logic               col_tick,
  output led_geom_pkg::col_t col
);
  import led_geom_pkg::*;

  localparam int CNT_W = $clog2(CLK_DIV);

  logic [CNT_W-1:0] div_cnt;
  logic             div_done;

  // Controller needs up to 5 cycles after the tick before the rising edge
  if (CLK_DIV < 6) begin : g_div_check
    $error("shift_clock_gen: CLK_DIV must be at least 6");
  end

  assign div_done = (div_cnt == CNT_W'(CLK_DIV - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt  <= '0;
      rgb_clk  <= 1'b0;
      col_tick <= 1'b0;
      col      <= '0;
    end else begin
      col_tick <= div_done && rgb_clk;  // falling toggle
      if (div_done) begin
        div_cnt <= '0;
        rgb_clk <= ~rgb_clk;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
      // Advance after the tick so the tick carries the current column
      if (col_tick) begin
        col <= (col == col_t'(PANEL_COLS - 1)) ? '0 : col + 1'b1;
      end
    end
  end

  a_tick_single: assert property (@(posedge clk) disable iff (!rst_n)
    col_tick |=> !col_tick)
    else $error("col_tick high on consecutive cycles");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build the LED matrix testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal \
    --top-module led_matrix_tb -f led_matrix_top.f &&
  ./obj_dir/Vled_matrix_tb | tee /dev/stderr | grep -qx "test passed" &&
  echo "Simulation result: PASS" ||
  { echo "Simulation result: FAIL"; exit 1; }

/* sim/led_matrix_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module led_matrix_tb;
  import led_geom_pkg::*;
  import led_scan_pkg::*;

  localparam int CLK_DIV     = 6;  // DUT defaults
  localparam int PWM_BITS    = 8;
  localparam int SCAN_CYCLES = SCAN_ROWS * PANEL_COLS * 2 * CLK_DIV;
  localparam int TEST_SCANS  = 1 + 2 + 1 + 5 + 2;  // reset, black, order, pwm, random
  localparam int MAX_CYCLES  = 2 * TEST_SCANS * SCAN_CYCLES;

  logic       clk;
  logic       rst_n;
  pixel_t     pixel;
  row_t       row;
  col_t       col;
  logic       write;
  logic       rgb_a;
  logic       rgb_b;
  logic       rgb_c;
  logic [2:0] rgb0;
  logic [2:0] rgb1;
  logic       rgb_stb;
  logic       rgb_clk;

  // Panel model state
  rgb_bits_t  line0 [PANEL_COLS];
  rgb_bits_t  line1 [PANEL_COLS];
  rgb_bits_t  img0 [PANEL_COLS];
  rgb_bits_t  img1 [PANEL_COLS];
  scan_row_t  img_addr;
  int         latch_count;
  logic       rgb_clk_q;

  pixel_t      image [PANEL_ROWS][PANEL_COLS];  // what the host wrote
  logic [31:0] lfsr_state;
  int          cycle_count = 0;

  led_matrix_top u_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .pixel   (pixel),
    .row     (row),
    .col     (col),
    .write   (write),
    .rgb_a   (rgb_a),
    .rgb_b   (rgb_b),
    .rgb_c   (rgb_c),
    .rgb0    (rgb0),
    .rgb1    (rgb1),
    .rgb_stb (rgb_stb),
    .rgb_clk (rgb_clk)
  );

  always #4 clk = ~clk;

  // Panel: shift on rising rgb_clk, latch on stb
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rgb_clk_q   <= 1'b0;
      latch_count <= 0;
    end else begin
      rgb_clk_q <= rgb_clk;
      if (rgb_clk && !rgb_clk_q) begin
        for (int i = 0; i < PANEL_COLS - 1; i++) begin
          line0[i] <= line0[i + 1];
          line1[i] <= line1[i + 1];
        end
        line0[PANEL_COLS - 1] <= rgb_bits_t'(rgb0);
        line1[PANEL_COLS - 1] <= rgb_bits_t'(rgb1);
      end
      if (rgb_stb) begin
        for (int i = 0; i < PANEL_COLS; i++) begin
          img0[i] <= line0[i];
          img1[i] <= line1[i];
        end
        img_addr    <= {rgb_c, rgb_b, rgb_a};
        latch_count <= latch_count + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
      report_failure("timeout");
    end
  end

  task automatic report_failure(string why);
    $display("test failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_rgb(string name, rgb_bits_t exp, rgb_bits_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
      report_failure("wrong rgb bits");
    end
  endtask

  task automatic check_row(string name, scan_row_t exp, scan_row_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
      report_failure("wrong scan row");
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
      report_failure("wrong bit");
    end
  endtask

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    if (s[0]) begin
      lfsr_next = (s >> 1) ^ 32'h8020_0003;
    end else begin
      lfsr_next = s >> 1;
    end
  endfunction

  task automatic random_pixel(output pixel_t p);
    logic [23:0] bits;
    int          i;
    for (i = 0; i < 24; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits[i] = lfsr_state[0];
    end
    p = pixel_t'(bits);
  endtask

  // Lit while the level is below the channel's top PWM_BITS
  function automatic rgb_bits_t expect_bits(pixel_t p, int level);
    rgb_bits_t b;
    int        shift;
    shift = 8 - PWM_BITS;
    b.r = (level < int'(p.red >> shift));
    b.g = (level < int'(p.green >> shift));
    b.b = (level < int'(p.blue >> shift));
    return b;
  endfunction

  function automatic pixel_t code_pixel(logic [2:0] code);
    pixel_t p;
    p.red   = {8{code[2]}};
    p.green = {8{code[1]}};
    p.blue  = {8{code[0]}};
    return p;
  endfunction

  // Upper and lower partner never share a color
  function automatic logic [2:0] row_code(int r);
    if (r < SCAN_ROWS) begin
      row_code = 3'((r % 7) + 1);
    end else begin
      row_code = 3'(((r - SCAN_ROWS + 3) % 7) + 1);
    end
  endfunction

  function automatic pixel_t pwm_pixel(int r, int g, int b);
    pixel_t p;
    p.red   = 8'(r << (8 - PWM_BITS));
    p.green = 8'(g << (8 - PWM_BITS));
    p.blue  = 8'(b << (8 - PWM_BITS));
    return p;
  endfunction

  task automatic write_pixel(row_t r, col_t c, pixel_t p);
    @(negedge clk);
    row   = r;
    col   = c;
    pixel = p;
    write = 1'b1;
    image[r][c] = p;
  endtask

  task automatic end_writes();
    @(negedge clk);
    write = 1'b0;
  endtask

  task automatic fill_image(pixel_t p);
    int r;
    int c;
    for (r = 0; r < PANEL_ROWS; r++) begin
      for (c = 0; c < PANEL_COLS; c++) begin
        write_pixel(row_t'(r), col_t'(c), p);
      end
    end
  endtask

  task automatic reset_dut();
    @(negedge clk);
    rst_n = 1'b0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic wait_latch();
    int start;
    start = latch_count;
    while (latch_count == start) begin
      @(negedge clk);
    end
  endtask

  task automatic check_outputs_idle(string name);
    check_bit(name, 1'b0, rgb_stb);
    check_rgb(name, '0, rgb_bits_t'(rgb0));
    check_rgb(name, '0, rgb_bits_t'(rgb1));
    check_row(name, '0, {rgb_c, rgb_b, rgb_a});
  endtask

  // Latched line against the image, row and level from the latch count
  task automatic check_latched_rule(string name);
    int k;
    int s;
    int level;
    int c;
    k     = latch_count - 1;
    s     = k % SCAN_ROWS;
    level = (k / SCAN_ROWS) % (1 << PWM_BITS);
    check_row(name, scan_row_t'(s), img_addr);
    for (c = 0; c < PANEL_COLS; c++) begin
      check_rgb($sformatf("%s row %0d col %0d", name, s, c),
                expect_bits(image[s][c], level), img0[c]);
      check_rgb($sformatf("%s row %0d col %0d", name, s + SCAN_ROWS, c),
                expect_bits(image[s + SCAN_ROWS][c], level), img1[c]);
    end
  endtask

  task automatic test_reset();
    int k;
    for (k = 0; k < 4; k++) begin
      @(negedge clk);
      check_outputs_idle("test_reset in reset");
      check_bit("test_reset rgb_clk in reset", 1'b0, rgb_clk);
    end
    rst_n = 1'b1;
    for (k = 1; k <= 4 * CLK_DIV; k++) begin
      @(negedge clk);
      check_bit($sformatf("test_reset rgb_clk cycle %0d", k),
                logic'((k / CLK_DIV) % 2), rgb_clk);
      if (k <= 2 * CLK_DIV) begin
        check_outputs_idle("test_reset after release");
      end
    end
  endtask

  task automatic test_full_and_black();
    int        n;
    int        s;
    int        c;
    rgb_bits_t exp;
    fill_image('0);
    write_pixel(row_t'(3), col_t'(5), '1);
    write_pixel(row_t'(11), col_t'(5), '1);
    end_writes();
    reset_dut();
    for (n = 0; n < 2 * SCAN_ROWS; n++) begin
      wait_latch();
      s = (latch_count - 1) % SCAN_ROWS;
      for (c = 0; c < PANEL_COLS; c++) begin
        exp = (s == 3 && c == 5) ? 3'b111 : 3'b000;
        check_rgb($sformatf("test_full_and_black row %0d col %0d", s, c), exp, img0[c]);
        check_rgb($sformatf("test_full_and_black row %0d col %0d", s + 8, c), exp, img1[c]);
      end
    end
  endtask

  task automatic test_line_order();
    int n;
    int r;
    int c;
    for (r = 0; r < PANEL_ROWS; r++) begin
      for (c = 0; c < PANEL_COLS; c++) begin
        write_pixel(row_t'(r), col_t'(c), code_pixel(row_code(r)));
      end
    end
    end_writes();
    reset_dut();
    for (n = 0; n < SCAN_ROWS; n++) begin
      wait_latch();
      check_row("test_line_order", scan_row_t'((latch_count - 1) % SCAN_ROWS), img_addr);
      check_row("test_line_order sequence", scan_row_t'(n), img_addr);
      for (c = 0; c < PANEL_COLS; c++) begin
        check_rgb("test_line_order upper", rgb_bits_t'(row_code(n)), img0[c]);
        check_rgb("test_line_order lower", rgb_bits_t'(row_code(n + SCAN_ROWS)), img1[c]);
      end
    end
  endtask

  task automatic test_pwm_levels();
    int n;
    fill_image('0);
    write_pixel(row_t'(2), col_t'(7), pwm_pixel(1, 3, 0));
    write_pixel(row_t'(10), col_t'(7), pwm_pixel(3, 0, 1));
    write_pixel(row_t'(6), col_t'(20), pwm_pixel(0, 1, 3));
    end_writes();
    reset_dut();
    for (n = 0; n < 5 * SCAN_ROWS; n++) begin
      wait_latch();
      check_latched_rule("test_pwm_levels");
    end
  endtask

  task automatic test_random_image();
    int     n;
    int     r;
    int     c;
    pixel_t p;
    for (r = 0; r < PANEL_ROWS; r++) begin
      for (c = 0; c < PANEL_COLS; c++) begin
        random_pixel(p);
        write_pixel(row_t'(r), col_t'(c), p);
      end
    end
    end_writes();
    reset_dut();
    for (n = 0; n < 2 * SCAN_ROWS; n++) begin
      wait_latch();
      check_latched_rule("test_random_image");
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    pixel      = '0;
    row        = '0;
    col        = '0;
    write      = 1'b0;
    lfsr_state = 32'h2635_a0d0;
    test_reset();
    test_full_and_black();
    test_line_order();
    test_pwm_levels();
    test_random_image();
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire
